// File: verilog.f
hw/life_pkg.sv
hw/video_timing.sv
hw/frame_ctrl.sv
hw/cell_fetch.sv
hw/pixel_compose.sv
hw/life_renderer.sv
bench/tb_life_renderer.sv

// File: Makefile
# Verilator build and run for the life renderer testbench

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_life_renderer
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in its output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_life_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_life_renderer;

    // longest wait is one whole frame plus some slack
    localparam int WAIT_LIMIT = int'(life_pkg::H_TOTAL) * int'(life_pkg::V_TOTAL) + 2000;

    logic                                clk_130mhz;
    logic                                rst_in;
    logic [life_pkg::WORD_SIZE-1:0]      data_in;
    life_pkg::pos_t                      view_x_in;
    life_pkg::pos_t                      view_y_in;
    life_pkg::pos_t                      cursor_x_in;
    life_pkg::pos_t                      cursor_y_in;
    logic [life_pkg::LOG_MAX_ADDR-1:0]   addr;
    logic [11:0]                         pix;
    logic                                hsync_out;
    logic                                vsync_out;
    logic                                done_out;

    // board memory model
    logic [life_pkg::WORD_SIZE-1:0] board [life_pkg::MAX_ADDR];

    // reference raster, position of the output sample at the next edge
    logic        locked = 1'b0;
    logic        vs_q = 1'b0;
    int          ref_h = 0;
    int          ref_v = 0;
    logic        check_en = 1'b0;
    logic        check_addr = 1'b0;
    logic [11:0] exp_pix = '0;
    logic        exp_hs = 1'b1;
    logic        exp_vs = 1'b1;
    logic        exp_done = 1'b1;
    logic [life_pkg::LOG_MAX_ADDR-1:0] exp_addr = '0;

    // view and cursor of the frame on the outputs
    life_pkg::pos_t fv_vx = '0;
    life_pkg::pos_t fv_vy = '0;
    life_pkg::pos_t fv_cx = '0;
    life_pkg::pos_t fv_cy = '0;

    int error_count = 0;
    int test_base = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    life_renderer u_life_renderer (
        .clk_130mhz  (clk_130mhz),
        .rst_in      (rst_in),
        .data_in     (data_in),
        .view_x_in   (view_x_in),
        .view_y_in   (view_y_in),
        .cursor_x_in (cursor_x_in),
        .cursor_y_in (cursor_y_in),
        .addr        (addr),
        .pix         (pix),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .done_out    (done_out)
    );

    initial begin
        clk_130mhz = 1'b0;
        forever #50 clk_130mhz = ~clk_130mhz;
    end

    // one cycle read latency
    always @(posedge clk_130mhz) begin
        data_in <= board[addr];
    end

    function automatic logic [11:0] expected_pixel(input int h, input int v);
        int          off_x;
        int          off_y;
        int          board_x;
        int          board_y;
        logic [15:0] word;
        bit          in_window;
        bit          on_border;
        if (h >= int'(life_pkg::SCREEN_WIDTH) || v >= int'(life_pkg::SCREEN_HEIGHT)) begin
            return 12'h000;
        end
        if (h == life_pkg::VIEW_PIX ||
            (h > life_pkg::VIEW_PIX && v == int'(life_pkg::FENCE_ROW))) begin
            return life_pkg::FENCE_COLOR;
        end
        in_window = (h < life_pkg::VIEW_PIX) && (v < life_pkg::VIEW_PIX);
        // cursor offset from the view origin, modulo the board size
        off_x = (int'(fv_cx) - int'(fv_vx) + life_pkg::BOARD_SIZE) % life_pkg::BOARD_SIZE;
        off_y = (int'(fv_cy) - int'(fv_vy) + life_pkg::BOARD_SIZE) % life_pkg::BOARD_SIZE;
        on_border = (h % 16 == 0) || (h % 16 == 15) || (v % 16 == 0) || (v % 16 == 15);
        if (in_window && off_x < life_pkg::VIEW_SIZE && off_y < life_pkg::VIEW_SIZE &&
            h / 16 == off_x && v / 16 == off_y && on_border) begin
            return life_pkg::CURSOR_COLOR;
        end
        board_x = (int'(fv_vx) + h / 16) % life_pkg::BOARD_SIZE;
        board_y = (int'(fv_vy) + v / 16) % life_pkg::BOARD_SIZE;
        word = board[board_y * life_pkg::WORDS_PER_ROW + board_x / life_pkg::WORD_SIZE];
        if (in_window && word[15 - board_x % 16]) begin
            return life_pkg::CELL_COLOR;
        end
        return 12'h000;
    endfunction

    always @(posedge clk_130mhz) begin : raster_model
        int h;
        int v;
        int ah;
        int bx;
        int by;
        int word_index;
        bit now_locked;
        h = ref_h;
        v = ref_v;
        // vsync falls on output position (0,771)
        now_locked = locked || (vs_q && !vsync_out);
        if (!locked) begin
            h = 0;
            v = int'(life_pkg::V_SYNC_START);
        end
        h = h + 1;
        if (h == int'(life_pkg::H_TOTAL)) begin
            h = 0;
            v = v + 1;
            if (v == int'(life_pkg::V_TOTAL)) begin
                v = 0;
            end
        end
        // inputs are held well away from frame start, so this is the latched view
        if (h == 0 && v == 0) begin
            fv_vx = view_x_in;
            fv_vy = view_y_in;
            fv_cx = cursor_x_in;
            fv_cy = cursor_y_in;
        end
        // read address runs three pixels ahead of the output
        ah = h + 3;
        bx = (int'(fv_vx) + ah / life_pkg::CELL_SIZE) % life_pkg::BOARD_SIZE;
        by = (int'(fv_vy) + v / life_pkg::CELL_SIZE) % life_pkg::BOARD_SIZE;
        word_index = by * life_pkg::WORDS_PER_ROW + bx / life_pkg::WORD_SIZE;
        vs_q     <= vsync_out;
        locked   <= now_locked;
        ref_h    <= h;
        ref_v    <= v;
        check_en <= rst_in || now_locked;
        check_addr <= now_locked && (ah < life_pkg::VIEW_PIX) && (v < life_pkg::VIEW_PIX);
        exp_addr <= word_index[life_pkg::LOG_MAX_ADDR-1:0];
        if (rst_in) begin
            exp_pix  <= 12'h000;
            exp_hs   <= 1'b1;
            exp_vs   <= 1'b1;
            exp_done <= 1'b1;
        end else begin
            exp_pix  <= expected_pixel(h, v);
            exp_hs   <= !(h >= int'(life_pkg::H_SYNC_START) && h < int'(life_pkg::H_SYNC_END));
            exp_vs   <= !(v >= int'(life_pkg::V_SYNC_START) && v < int'(life_pkg::V_SYNC_END));
            exp_done <= (v >= int'(life_pkg::SCREEN_HEIGHT));
        end
    end

    task automatic show_error(input string name, input logic [11:0] expected,
                              input logic [11:0] actual, input int h, input int v);
        error_count++;
        $display("error: %s expected %h got %h at raster %0d,%0d", name, expected, actual, h, v);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_base;
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errs);
        test_base = error_count;
    endtask

    // waits until the output raster reaches the start of a line
    task automatic wait_line(input int line, output bit ok);
        int n;
        n = 0;
        while (!(locked && ref_v == line && ref_h == 0) && n < WAIT_LIMIT) begin
            @(posedge clk_130mhz);
            n++;
        end
        ok = (n < WAIT_LIMIT);
        if (!ok) begin
            $display("timeout: output line %0d not reached within %0d cycles", line, WAIT_LIMIT);
        end
    endtask

    task automatic apply_view(input int vx, input int vy, input int cx, input int cy);
        view_x_in   <= life_pkg::pos_t'(vx);
        view_y_in   <= life_pkg::pos_t'(vy);
        cursor_x_in <= life_pkg::pos_t'(cx);
        cursor_y_in <= life_pkg::pos_t'(cy);
    endtask

    // reset values, sync timing, done and every pixel against the reference
    assert property (@(posedge clk_130mhz) check_en |-> (pix == exp_pix))
        else show_error("pix", $sampled(exp_pix), $sampled(pix),
                        $sampled(ref_h), $sampled(ref_v));
    assert property (@(posedge clk_130mhz) check_en |-> (hsync_out == exp_hs))
        else show_error("hsync_out", 12'($sampled(exp_hs)), 12'($sampled(hsync_out)),
                        $sampled(ref_h), $sampled(ref_v));
    assert property (@(posedge clk_130mhz) check_en |-> (vsync_out == exp_vs))
        else show_error("vsync_out", 12'($sampled(exp_vs)), 12'($sampled(vsync_out)),
                        $sampled(ref_h), $sampled(ref_v));
    assert property (@(posedge clk_130mhz) check_en |-> (done_out == exp_done))
        else show_error("done_out", 12'($sampled(exp_done)), 12'($sampled(done_out)),
                        $sampled(ref_h), $sampled(ref_v));

    // board word address while the fetch is inside the window
    assert property (@(posedge clk_130mhz) check_addr |-> (addr == exp_addr))
        else show_error("addr", 12'($sampled(exp_addr)), 12'($sampled(addr)),
                        $sampled(ref_h), $sampled(ref_v));

    initial begin
        bit          ok;
        int          i;
        logic [31:0] rnd;
        rst_in      = 1'b1;
        data_in     = '0;
        view_x_in   = '0;
        view_y_in   = '0;
        cursor_x_in = '0;
        cursor_y_in = '0;
        ok          = 1'b1;
        rnd = $urandom(32);
        for (i = 0; i < life_pkg::MAX_ADDR; i++) begin
            rnd = $urandom();
            board[i] = rnd[15:0];
        end

        repeat (16) @(posedge clk_130mhz);
        rst_in <= 1'b0;
        repeat (2) @(posedge clk_130mhz);
        finish_test("reset state");

        // frame 1 view wraps on x
        wait_line(780, ok);
        if (ok) begin
            apply_view(40, 8, 45, 30);
            wait_line(0, ok);
        end
        if (ok) begin
            wait_line(780, ok);
        end
        if (ok) begin
            finish_test("frame 1 wrapped view with cursor");
            // cursor offset only lands in the window through the wrap
            apply_view(60, 50, 1, 59);
            wait_line(0, ok);
        end
        if (ok) begin
            wait_line(200, ok);
        end
        if (ok) begin
            // mid-frame move, shows up in frame 3 only
            apply_view(20, 20, 0, 0);
            wait_line(780, ok);
        end
        if (ok) begin
            finish_test("frame 2 mid-frame change held off");
            wait_line(0, ok);
        end
        if (ok) begin
            wait_line(780, ok);
        end
        if (ok) begin
            finish_test("frame 3 cursor outside window");
        end

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (ok && error_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/life_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module life_renderer (
    input  wire                                clk_130mhz,
    input  wire                                rst_in,
    input  wire  [life_pkg::WORD_SIZE-1:0]     data_in,
    input  wire  life_pkg::pos_t               view_x_in,
    input  wire  life_pkg::pos_t               view_y_in,
    input  wire  life_pkg::pos_t               cursor_x_in,
    input  wire  life_pkg::pos_t               cursor_y_in,
    output logic [life_pkg::LOG_MAX_ADDR-1:0]  addr,
    output logic [11:0]                        pix,
    output logic                               hsync_out,
    output logic                               vsync_out,
    output logic                               done_out
);

    logic [10:0]    hcount;
    logic [9:0]     vcount;
    logic           hsync_n;
    logic           vsync_n;
    logic           blank;
    logic           frame_start;
    logic           vblank_start;
    logic           done;
    logic           is_alive;
    life_pkg::pos_t view_x;
    life_pkg::pos_t view_y;
    life_pkg::pos_t cursor_x;
    life_pkg::pos_t cursor_y;

    video_timing u_video_timing (
        .clk_130mhz   (clk_130mhz),
        .rst_in       (rst_in),
        .hcount       (hcount),
        .vcount       (vcount),
        .hsync_n      (hsync_n),
        .vsync_n      (vsync_n),
        .blank        (blank),
        .frame_start  (frame_start),
        .vblank_start (vblank_start)
    );

    frame_ctrl u_frame_ctrl (
        .clk_130mhz   (clk_130mhz),
        .rst_in       (rst_in),
        .frame_start  (frame_start),
        .vblank_start (vblank_start),
        .view_x_in    (view_x_in),
        .view_y_in    (view_y_in),
        .cursor_x_in  (cursor_x_in),
        .cursor_y_in  (cursor_y_in),
        .view_x       (view_x),
        .view_y       (view_y),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .done         (done)
    );

    // board read, three cycles from position to is_alive
    cell_fetch u_cell_fetch (
        .clk_130mhz (clk_130mhz),
        .hcount     (hcount),
        .vcount     (vcount),
        .view_x     (view_x),
        .view_y     (view_y),
        .data_in    (data_in),
        .addr       (addr),
        .is_alive   (is_alive)
    );

    pixel_compose u_pixel_compose (
        .clk_130mhz (clk_130mhz),
        .rst_in     (rst_in),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync_n    (hsync_n),
        .vsync_n    (vsync_n),
        .blank      (blank),
        .done       (done),
        .view_x     (view_x),
        .view_y     (view_y),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .is_alive   (is_alive),
        .pix        (pix),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .done_out   (done_out)
    );

endmodule

`default_nettype wire

// File: hw/pixel_compose.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compose (
    input  wire         clk_130mhz,
    input  wire         rst_in,
    input  wire  [10:0] hcount,
    input  wire  [9:0]  vcount,
    input  wire         hsync_n,
    input  wire         vsync_n,
    input  wire         blank,
    input  wire         done,
    input  wire         life_pkg::pos_t view_x,
    input  wire         life_pkg::pos_t view_y,
    input  wire         life_pkg::pos_t cursor_x,
    input  wire         life_pkg::pos_t cursor_y,
    input  wire         is_alive,
    output logic [11:0] pix,
    output logic        hsync_out,
    output logic        vsync_out,
    output logic        done_out
);

    // three stages to meet is_alive from the fetch
    logic [10:0] h_d [3];
    logic [9:0]  v_d [3];
    logic [2:0]  hs_d;
    logic [2:0]  vs_d;
    logic [2:0]  blank_d;
    logic [2:0]  done_d;

    logic [10:0] h3;
    logic [9:0]  v3;
    logic [life_pkg::LOG_CELL_SIZE-1:0] sub_x;
    logic [life_pkg::LOG_CELL_SIZE-1:0] sub_y;
    life_pkg::pos_t off_x;
    life_pkg::pos_t off_y;
    logic in_window;
    logic on_fence;
    logic cursor_visible;
    logic in_cursor_cell;
    logic on_cell_edge;
    logic on_cursor;

    always_ff @(posedge clk_130mhz) begin
        if (rst_in) begin
            hs_d    <= '1;
            vs_d    <= '1;
            blank_d <= '1;
            done_d  <= '1;
        end else begin
            hs_d    <= {hs_d[1:0], hsync_n};
            vs_d    <= {vs_d[1:0], vsync_n};
            blank_d <= {blank_d[1:0], blank};
            done_d  <= {done_d[1:0], done};
        end
    end

    always_ff @(posedge clk_130mhz) begin
        h_d[0] <= hcount;
        h_d[1] <= h_d[0];
        h_d[2] <= h_d[1];
        v_d[0] <= vcount;
        v_d[1] <= v_d[0];
        v_d[2] <= v_d[1];
    end

    always_comb begin
        h3 = h_d[2];
        v3 = v_d[2];
        in_window = (h3 < life_pkg::VIEW_PIX) && (v3 < life_pkg::VIEW_PIX);
        on_fence = (h3 == life_pkg::VIEW_PIX) ||
                   ((h3 > life_pkg::VIEW_PIX) && (v3 == life_pkg::FENCE_ROW));

        // cursor relative to the view origin, wraps like the board
        off_x = cursor_x - view_x;
        off_y = cursor_y - view_y;
        cursor_visible = (off_x < life_pkg::VIEW_SIZE) && (off_y < life_pkg::VIEW_SIZE);
        in_cursor_cell = in_window &&
            (h3[life_pkg::LOG_CELL_SIZE +: life_pkg::LOG_BOARD_SIZE] == off_x) &&
            (v3[life_pkg::LOG_CELL_SIZE +: life_pkg::LOG_BOARD_SIZE] == off_y);

        // first or last pixel of a cell on either axis
        sub_x = h3[life_pkg::LOG_CELL_SIZE-1:0];
        sub_y = v3[life_pkg::LOG_CELL_SIZE-1:0];
        on_cell_edge = (sub_x == '0) || (&sub_x) || (sub_y == '0) || (&sub_y);
        on_cursor = cursor_visible && in_cursor_cell && on_cell_edge;
    end

    always_ff @(posedge clk_130mhz) begin
        if (rst_in) begin
            pix       <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            done_out  <= 1'b1;
        end else begin
            hsync_out <= hs_d[2];
            vsync_out <= vs_d[2];
            // frame phase trails the raster by a cycle, the line pins it down
            done_out  <= done_d[2] && (v3 >= life_pkg::SCREEN_HEIGHT);

            if (blank_d[2]) begin
                pix <= '0;
            end else if (on_fence) begin
                pix <= life_pkg::FENCE_COLOR;
            end else if (on_cursor) begin
                pix <= life_pkg::CURSOR_COLOR;
            end else if (in_window && is_alive) begin
                pix <= life_pkg::CELL_COLOR;
            end else begin
                pix <= '0;
            end
        end
    end

    // nothing is drawn outside the visible raster
    assert property (@(posedge clk_130mhz) disable iff (rst_in)
        blank_d[2] |=> (pix == '0));

endmodule

`default_nettype wire

// File: hw/cell_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cell_fetch (
    input  wire                                clk_130mhz,
    input  wire  [10:0]                        hcount,
    input  wire  [9:0]                         vcount,
    input  wire  life_pkg::pos_t               view_x,
    input  wire  life_pkg::pos_t               view_y,
    input  wire  [life_pkg::WORD_SIZE-1:0]     data_in,
    output logic [life_pkg::LOG_MAX_ADDR-1:0]  addr,
    output logic                               is_alive
);

    life_pkg::pos_t                    board_x;
    life_pkg::pos_t                    board_y;
    logic [life_pkg::LOG_WORD_SIZE-1:0] bit_d1;
    logic [life_pkg::LOG_WORD_SIZE-1:0] bit_d2;

    // pixel to view cell, then add the origin
    // the 6-bit sum wraps around the board edge
    always_comb begin
        board_x = view_x + hcount[life_pkg::LOG_CELL_SIZE +: life_pkg::LOG_BOARD_SIZE];
        board_y = view_y + vcount[life_pkg::LOG_CELL_SIZE +: life_pkg::LOG_BOARD_SIZE];
    end

    always_ff @(posedge clk_130mhz) begin
        // word y * WORDS_PER_ROW + x / WORD_SIZE
        addr <= {board_y, board_x[life_pkg::LOG_BOARD_SIZE-1:life_pkg::LOG_WORD_SIZE]};

        // bit offset waits for the memory read
        bit_d1 <= board_x[life_pkg::LOG_WORD_SIZE-1:0];
        bit_d2 <= bit_d1;

        // leftmost cell is the MSB: bit 15 minus the offset,
        // which is the complement of a 4-bit offset
        is_alive <= data_in[~bit_d2];
    end

    // address always lands inside the board memory
    assert property (@(posedge clk_130mhz)
        !$isunknown(hcount) |=> (addr < life_pkg::MAX_ADDR));

endmodule

`default_nettype wire

// File: hw/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl (
    input  wire            clk_130mhz,
    input  wire            rst_in,
    input  wire            frame_start,
    input  wire            vblank_start,
    input  wire            life_pkg::pos_t view_x_in,
    input  wire            life_pkg::pos_t view_y_in,
    input  wire            life_pkg::pos_t cursor_x_in,
    input  wire            life_pkg::pos_t cursor_y_in,
    output life_pkg::pos_t view_x,
    output life_pkg::pos_t view_y,
    output life_pkg::pos_t cursor_x,
    output life_pkg::pos_t cursor_y,
    output logic           done
);

    life_pkg::frame_state_t state;
    life_pkg::pos_t         view_x_q;
    life_pkg::pos_t         view_y_q;
    life_pkg::pos_t         cursor_x_q;
    life_pkg::pos_t         cursor_y_q;

    always_ff @(posedge clk_130mhz) begin
        if (rst_in) begin
            state      <= life_pkg::FRAME_BLANK;
            view_x_q   <= '0;
            view_y_q   <= '0;
            cursor_x_q <= '0;
            cursor_y_q <= '0;
        end else begin
            case (state)
                life_pkg::FRAME_ACTIVE: begin
                    if (vblank_start) begin
                        state <= life_pkg::FRAME_BLANK;
                    end
                end
                life_pkg::FRAME_BLANK: begin
                    if (frame_start) begin
                        state <= life_pkg::FRAME_ACTIVE;
                    end
                end
                default: state <= life_pkg::FRAME_BLANK;
            endcase

            // one sample per frame
            if (frame_start) begin
                view_x_q   <= view_x_in;
                view_y_q   <= view_y_in;
                cursor_x_q <= cursor_x_in;
                cursor_y_q <= cursor_y_in;
            end
        end
    end

    // pixel (0,0) is fetched in the frame_start cycle itself,
    // so the new sample goes straight through for that cycle
    always_comb begin
        if (frame_start) begin
            view_x   = view_x_in;
            view_y   = view_y_in;
            cursor_x = cursor_x_in;
            cursor_y = cursor_y_in;
        end else begin
            view_x   = view_x_q;
            view_y   = view_y_q;
            cursor_x = cursor_x_q;
            cursor_y = cursor_y_q;
        end
    end

    assign done = (state == life_pkg::FRAME_BLANK);

    // the timing block never fires both frame events at once
    assert property (@(posedge clk_130mhz) disable iff (rst_in)
        !(frame_start && vblank_start));

endmodule

`default_nettype wire

// File: hw/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire         clk_130mhz,
    input  wire         rst_in,
    output logic [10:0] hcount,
    output logic [9:0]  vcount,
    output logic        hsync_n,
    output logic        vsync_n,
    output logic        blank,
    output logic        frame_start,
    output logic        vblank_start
);

    logic        line_end;
    logic [10:0] h_next;
    logic [9:0]  v_next;

    // next raster position
    // all decodes work from it so every output changes with the counters
    always_comb begin
        line_end = (hcount == life_pkg::H_TOTAL - 11'd1);
        h_next = line_end ? 11'd0 : hcount + 11'd1;
        if (!line_end) begin
            v_next = vcount;
        end else if (vcount == life_pkg::V_TOTAL - 10'd1) begin
            v_next = 10'd0;
        end else begin
            v_next = vcount + 10'd1;
        end
    end

    always_ff @(posedge clk_130mhz) begin
        if (rst_in) begin
            hcount       <= '0;
            vcount       <= '0;
            hsync_n      <= 1'b1;
            vsync_n      <= 1'b1;
            blank        <= 1'b0;
            // first full frame starts at the next wrap
            frame_start  <= 1'b0;
            vblank_start <= 1'b0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;

            // both syncs active low
            hsync_n <= !((h_next >= life_pkg::H_SYNC_START) &&
                         (h_next < life_pkg::H_SYNC_END));
            vsync_n <= !((v_next >= life_pkg::V_SYNC_START) &&
                         (v_next < life_pkg::V_SYNC_END));

            blank <= (h_next >= life_pkg::SCREEN_WIDTH) ||
                     (v_next >= life_pkg::SCREEN_HEIGHT);

            frame_start  <= (h_next == 11'd0) && (v_next == 10'd0);
            // last visible pixel of the frame
            vblank_start <= (h_next == life_pkg::SCREEN_WIDTH - 11'd1) &&
                            (v_next == life_pkg::SCREEN_HEIGHT - 10'd1);
        end
    end

    // counters never leave the raster
    assert property (@(posedge clk_130mhz) disable iff (rst_in)
        (hcount < life_pkg::H_TOTAL) && (vcount < life_pkg::V_TOTAL));

endmodule

`default_nettype wire

// File: hw/life_pkg.sv
`default_nettype none

package life_pkg;

    // 1024x768 raster, horizontal values in pixels, vertical in lines
    localparam logic [10:0] SCREEN_WIDTH  = 11'd1024;
    localparam logic [9:0]  SCREEN_HEIGHT = 10'd768;
    localparam logic [10:0] H_SYNC_START  = 11'd1048;
    localparam logic [10:0] H_SYNC_END    = 11'd1184;
    localparam logic [10:0] H_TOTAL       = 11'd1344;
    localparam logic [9:0]  V_SYNC_START  = 10'd771;
    localparam logic [9:0]  V_SYNC_END    = 10'd777;
    localparam logic [9:0]  V_TOTAL       = 10'd806;

    // cell, window and board geometry
    localparam int CELL_SIZE      = 16;
    localparam int LOG_CELL_SIZE  = 4;
    localparam int VIEW_SIZE      = 32;
    localparam int VIEW_PIX       = VIEW_SIZE * CELL_SIZE;
    localparam int BOARD_SIZE     = 64;
    localparam int LOG_BOARD_SIZE = 6;

    // board memory, one row of cells spread over four words
    localparam int WORD_SIZE      = 16;
    localparam int LOG_WORD_SIZE  = 4;
    localparam int WORDS_PER_ROW  = BOARD_SIZE / WORD_SIZE;
    localparam int MAX_ADDR       = BOARD_SIZE * WORDS_PER_ROW;
    localparam int LOG_MAX_ADDR   = 8;

    // horizontal fence line on the right half of the screen
    localparam logic [9:0] FENCE_ROW = 10'd384;

    localparam logic [11:0] CELL_COLOR   = 12'h0F0;
    localparam logic [11:0] CURSOR_COLOR = 12'hF00;
    localparam logic [11:0] FENCE_COLOR  = 12'hFFF;

    // board coordinate, sums and differences wrap modulo 64
    typedef logic [LOG_BOARD_SIZE-1:0] pos_t;

    typedef enum logic {
        FRAME_ACTIVE,
        FRAME_BLANK
    } frame_state_t;

endpackage

`default_nettype wire
